//--- compile.f
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_decode.sv
hdl/regfile.sv
hdl/int_execute.sv
hdl/commit_stage.sv
hdl/core_top.sv
test/core_props.sv
test/core_tb.sv

//--- Bender.yml
package:
  name: la_int_backend

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/instr_decode.sv
      - hdl/regfile.sv
      - hdl/int_execute.sv
      - hdl/commit_stage.sv
      - hdl/core_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/core_props.sv
      - test/core_tb.sv

//--- test/core_tb.sv
`default_nettype none

`include "core_settings.svh"

module core_tb;
    import core_pkg::*;

    localparam int N_LOAD      = 2 * (`CORE_NUM_REGS - 1);
    localparam int N_RAND      = 40;
    localparam int N_CHAIN     = 24;
    localparam int N_SPECIAL   = 5;
    localparam int TOTAL_INSTR = N_LOAD + N_RAND + N_CHAIN + N_SPECIAL;
    localparam int TIMEOUT_CYC = TOTAL_INSTR * 12 + 64;

    logic    clk;
    logic    rst_i;
    logic    instr_req;
    instr_t  instr_data;
    logic    instr_ack;
    commit_t commit;

    word_t       model_rf [`CORE_NUM_REGS];  // Architectural state in program order
    word_t       model_pc;
    commit_t     exp_q [$];
    logic [31:0] lfsr_state;
    int          errors;
    int          n_tests;
    int          n_failed_tests;
    int          n_commits;

    core_top uut (
        .clk          (clk),
        .rst_i        (rst_i),
        .instr_req_i  (instr_req),
        .instr_data_i (instr_data),
        .instr_ack_o  (instr_ack),
        .commit_o     (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic instr_t enc_3r(input logic [16:0] op, input reg_addr_t rk,
                                      input reg_addr_t rj, input reg_addr_t rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic instr_t enc_addi(input logic [11:0] si12, input reg_addr_t rj,
                                        input reg_addr_t rd);
        return {`CORE_OP_ADDI_W, si12, rj, rd};
    endfunction

    function automatic instr_t enc_lu12i(input logic [19:0] si20, input reg_addr_t rd);
        return {`CORE_OP_LU12I_W, si20, rd};
    endfunction

    function automatic logic [16:0] op_3r_code(input int idx);
        case (idx)
            0:       return `CORE_OP_ADD_W;
            1:       return `CORE_OP_SUB_W;
            2:       return `CORE_OP_AND;
            3:       return `CORE_OP_OR;
            4:       return `CORE_OP_XOR;
            5:       return `CORE_OP_SLT;
            default: return `CORE_OP_SLTU;
        endcase
    endfunction

    // Expected trace entry from the instruction semantics
    function automatic commit_t ref_commit(input word_t rf [`CORE_NUM_REGS], input word_t pc,
                                           input instr_t ins);
        commit_t c;
        word_t   a;
        word_t   b;
        logic    known;
        a       = (ins[9:5] == 0) ? '0 : rf[ins[9:5]];
        b       = (ins[14:10] == 0) ? '0 : rf[ins[14:10]];
        known   = 1'b1;
        c       = '0;
        c.valid = 1'b1;
        c.pc    = pc;
        c.wnum  = ins[4:0];
        if (ins[31:22] == `CORE_OP_ADDI_W) begin
            c.wdata = a + {{20{ins[21]}}, ins[21:10]};
        end else if (ins[31:25] == `CORE_OP_LU12I_W) begin
            c.wdata = {ins[24:5], 12'h000};
        end else begin
            case (ins[31:15])
                `CORE_OP_ADD_W: c.wdata = a + b;
                `CORE_OP_SUB_W: c.wdata = a - b;
                `CORE_OP_AND:   c.wdata = a & b;
                `CORE_OP_OR:    c.wdata = a | b;
                `CORE_OP_XOR:   c.wdata = a ^ b;
                `CORE_OP_SLT:   c.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `CORE_OP_SLTU:  c.wdata = (a < b) ? 32'd1 : 32'd0;
                default:        known = 1'b0;
            endcase
        end
        c.wen = known && (c.wnum != 0);
        return c;
    endfunction

    // Four-phase transfer of one instruction
    task automatic send_instr(input instr_t ins);
        commit_t exp_c;
        exp_c = ref_commit(model_rf, model_pc, ins);
        exp_q.push_back(exp_c);
        if (exp_c.wen) model_rf[exp_c.wnum] = exp_c.wdata;
        model_pc = model_pc + 32'd4;
        instr_req  <= 1'b1;
        instr_data <= ins;
        do @(posedge clk); while (!instr_ack);
        instr_req <= 1'b0;
        do @(posedge clk); while (instr_ack);  // Next req as soon as ack is low
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        while (exp_q.size() != 0) @(posedge clk);  // Drain outstanding commits
        n_tests++;
        if (errors == errs_at_start) begin
            $display("test %-8s ok", name);
        end else begin
            n_failed_tests++;
            $display("test %-8s FAILED with %0d errors", name, errors - errs_at_start);
        end
    endtask

    // Compare every retired instruction against the model
    always @(posedge clk) begin
        commit_t exp_c;
        if (!rst_i && commit.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Commit at time %0t with no instruction outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_c = exp_q.pop_front();
                n_commits++;
                assert (commit.pc == exp_c.pc) else begin
                    $display("[FAIL] t=%0t pc got %h expected %h", $time, commit.pc, exp_c.pc);
                    errors++;
                end
                assert (commit.wen == exp_c.wen) else begin
                    $display("[FAIL] t=%0t pc %h wen got %b expected %b",
                             $time, exp_c.pc, commit.wen, exp_c.wen);
                    errors++;
                end
                assert (!exp_c.wen || commit.wnum == exp_c.wnum) else begin
                    $display("[FAIL] t=%0t pc %h wnum got %0d expected %0d",
                             $time, exp_c.pc, commit.wnum, exp_c.wnum);
                    errors++;
                end
                assert (!exp_c.wen || commit.wdata == exp_c.wdata) else begin
                    $display("[FAIL] t=%0t pc %h wdata got %h expected %h",
                             $time, exp_c.pc, commit.wdata, exp_c.wdata);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped answering", TIMEOUT_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          errs0;
        reg_addr_t   prev_rd;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        logic [31:0] pick;
        rst_i          = 1'b1;
        instr_req      = 1'b0;
        instr_data     = '0;
        lfsr_state     = 32'h5d5f;
        model_pc       = `CORE_RESET_PC;
        errors         = 0;
        n_tests        = 0;
        n_failed_tests = 0;
        n_commits      = 0;
        for (int i = 0; i < `CORE_NUM_REGS; i++) model_rf[i] = '0;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;

        errs0 = errors;
        repeat (4) begin
            @(posedge clk);
            assert (!instr_ack && !commit.valid) else begin
                $display("[FAIL] t=%0t ack %b or commit valid %b high after reset",
                         $time, instr_ack, commit.valid);
                errors++;
            end
        end
        end_test("reset", errs0);

        errs0 = errors;
        for (int r = 1; r < `CORE_NUM_REGS; r++) begin
            send_instr(enc_lu12i(20'(rand_bits(20)), r[4:0]));
            send_instr(enc_addi(12'(rand_bits(12)), r[4:0], r[4:0]));
        end
        end_test("load", errs0);

        errs0 = errors;
        for (int i = 0; i < N_RAND; i++) begin
            pick = rand_bits(3);
            rk   = 5'(rand_bits(5));
            rj   = 5'(rand_bits(5));
            rd   = 5'(rand_bits(5));
            send_instr(enc_3r(op_3r_code(pick % 7), rk, rj, rd));
        end
        end_test("alu", errs0);

        errs0   = errors;
        prev_rd = 5'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'(rand_bits(5));
            if (rd == 0) rd = 5'd7;
            pick = rand_bits(3);
            if (pick == 7) begin
                send_instr(enc_addi(12'(rand_bits(12)), prev_rd, rd));
            end else begin
                // Second source is the previous result or any register
                rk = rand_bits(1) ? prev_rd : 5'(rand_bits(5));
                send_instr(enc_3r(op_3r_code(pick), rk, prev_rd, rd));
            end
            prev_rd = rd;
        end
        end_test("chain", errs0);

        errs0 = errors;
        send_instr(enc_3r(`CORE_OP_ADD_W, 5'd4, 5'd3, 5'd0));  // rd of zero
        send_instr(enc_3r(17'h0002c, 5'd2, 5'd3, 5'd9));       // Not in the subset
        send_instr(enc_3r(`CORE_OP_ADD_W, 5'd0, 5'd9, 5'd10));
        send_instr(enc_3r(`CORE_OP_OR, 5'd0, 5'd0, 5'd11));
        send_instr(enc_3r(`CORE_OP_ADD_W, 5'd1, 5'd0, 5'd12));
        end_test("nowrite", errs0);

        repeat (2) @(posedge clk);  // Last commit pulse still under property check

        $display("Summary: %0d tests, %0d failing, %0d commits, %0d errors, %0d property errors",
                 n_tests, n_failed_tests, n_commits, errors, uut.u_props.fail_count);
        if (errors == 0 && uut.u_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/core_props.sv
`default_nettype none

`include "core_settings.svh"

module core_props (
    input wire                clk,
    input wire                rst_i,
    input wire                req_i,
    input wire                ack_i,
    input core_pkg::commit_t  commit_i
);
    import core_pkg::*;

    int fail_count = 0;  // Read by the testbench summary

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    // ack drops only once req has gone low
    ack_fall_needs_req_low: assert property (@(posedge clk) disable iff (rst_i)
        $fell(ack_i) |-> $past(!req_i))
        else begin
            $error("ack fell while req was still high");
            fail_count++;
        end

    commit_single_cycle: assert property (@(posedge clk) disable iff (rst_i)
        commit_i.valid |=> !commit_i.valid)
        else begin
            $error("commit valid held for two cycles");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $past(rst_i) |-> (!ack_i && !commit_i.valid))
        else begin
            $error("ack or commit valid high in the cycle after reset");
            fail_count++;
        end

endmodule

bind core_top core_props u_props (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (instr_req_i),
    .ack_i    (instr_ack_o),
    .commit_i (commit_o)
);

`default_nettype wire

//--- hdl/core_top.sv
`default_nettype none

`include "core_settings.svh"

module core_top (
    input  wire               clk,
    input  wire               rst_i,
    input  wire               instr_req_i,
    input  core_pkg::instr_t  instr_data_i,
    output logic              instr_ack_o,
    output core_pkg::commit_t commit_o
);
    import core_pkg::*;

    decode_pkt_t dec_pkt;
    exec_pkt_t   exe_pkt;
    rf_write_t   rf_wr;
    reg_addr_t   rf_raddr_a;
    reg_addr_t   rf_raddr_b;
    word_t       rf_rdata_a;
    word_t       rf_rdata_b;

    instr_decode u_instr_decode (
        .clk          (clk),
        .rst_i        (rst_i),
        .instr_req_i  (instr_req_i),
        .instr_data_i (instr_data_i),
        .instr_ack_o  (instr_ack_o),
        .dec_o        (dec_pkt)
    );

    // Operands are read in execute
    regfile u_regfile (
        .clk       (clk),
        .rst_i     (rst_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .wr_i      (rf_wr)
    );

    int_execute u_int_execute (
        .clk          (clk),
        .rst_i        (rst_i),
        .dec_i        (dec_pkt),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .exe_o        (exe_pkt)
    );

    commit_stage u_commit_stage (
        .clk      (clk),
        .rst_i    (rst_i),
        .exe_i    (exe_pkt),
        .rf_wr_o  (rf_wr),
        .commit_o (commit_o)  // Trace port
    );

endmodule

`default_nettype wire

//--- hdl/commit_stage.sv
`default_nettype none

`include "core_settings.svh"

module commit_stage (
    input  wire                 clk,
    input  wire                 rst_i,
    input  core_pkg::exec_pkt_t exe_i,
    output core_pkg::rf_write_t rf_wr_o,
    output core_pkg::commit_t   commit_o
);
    import core_pkg::*;

    commit_t commit_q;
    logic    retire_we;

    // Retirement point, regfile takes the write on the same edge as the trace
    assign retire_we = exe_i.valid && exe_i.wen;

    assign rf_wr_o.we    = retire_we;
    assign rf_wr_o.waddr = exe_i.rd;
    assign rf_wr_o.wdata = exe_i.result;

    always_ff @(posedge clk) begin
        if (exe_i.valid) begin
            commit_q.pc    <= exe_i.pc;
            commit_q.wen   <= retire_we;
            commit_q.wnum  <= exe_i.rd;
            commit_q.wdata <= exe_i.result;
        end
        if (rst_i) begin
            commit_q.valid <= 1'b0;
        end else begin
            commit_q.valid <= exe_i.valid;  // Single cycle pulse per instruction
        end
    end

    assign commit_o = commit_q;

endmodule

`default_nettype wire

//--- hdl/int_execute.sv
`default_nettype none

`include "core_settings.svh"

module int_execute (
    input  wire                   clk,
    input  wire                   rst_i,
    input  core_pkg::decode_pkt_t dec_i,
    output core_pkg::reg_addr_t   rf_raddr_a_o,
    output core_pkg::reg_addr_t   rf_raddr_b_o,
    input  core_pkg::word_t       rf_rdata_a_i,
    input  core_pkg::word_t       rf_rdata_b_i,
    output core_pkg::exec_pkt_t   exe_o
);
    import core_pkg::*;

    exec_pkt_t exe_q;
    logic      fwd_a;
    logic      fwd_b;
    word_t     reg_a;
    word_t     reg_b;
    word_t     src_a;
    word_t     src_b;
    word_t     result;
    logic      lt_signed;
    logic      lt_unsigned;

    assign rf_raddr_a_o = dec_i.rj;
    assign rf_raddr_b_o = dec_i.rk;

    // The instruction in exe_q has not reached the regfile yet
    // wen is already clear for rd == 0
    assign fwd_a = exe_q.valid && exe_q.wen && (exe_q.rd == dec_i.rj);
    assign fwd_b = exe_q.valid && exe_q.wen && (exe_q.rd == dec_i.rk);

    assign reg_a = fwd_a ? exe_q.result : rf_rdata_a_i;
    assign reg_b = fwd_b ? exe_q.result : rf_rdata_b_i;

    assign src_a = reg_a;
    assign src_b = dec_i.use_imm ? dec_i.imm : reg_b;

    assign lt_signed   = $signed(src_a) < $signed(src_b);
    assign lt_unsigned = src_a < src_b;

    always_comb begin
        case (dec_i.alu_op)
            alu_add:  result = src_a + src_b;
            alu_sub:  result = src_a - src_b;
            alu_and:  result = src_a & src_b;
            alu_or:   result = src_a | src_b;
            alu_xor:  result = src_a ^ src_b;
            alu_slt:  result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            alu_lui:  result = dec_i.imm;  // Immediate passes straight through
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (dec_i.valid) begin
            exe_q.pc     <= dec_i.pc;
            exe_q.rd     <= dec_i.rd;
            exe_q.wen    <= dec_i.wen;
            exe_q.result <= result;
        end
        if (rst_i) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q.valid <= dec_i.valid;
        end
    end

    assign exe_o = exe_q;

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none

`include "core_settings.svh"

module regfile (
    input  wire                 clk,
    input  wire                 rst_i,
    input  core_pkg::reg_addr_t raddr_a_i,
    input  core_pkg::reg_addr_t raddr_b_i,
    output core_pkg::word_t     rdata_a_o,
    output core_pkg::word_t     rdata_b_o,
    input  core_pkg::rf_write_t wr_i
);
    import core_pkg::*;

    word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.waddr != '0)) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // r0 is hardwired
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- hdl/instr_decode.sv
`default_nettype none

`include "core_settings.svh"

module instr_decode (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire                  instr_req_i,
    input  core_pkg::instr_t     instr_data_i,
    output logic                 instr_ack_o,
    output core_pkg::decode_pkt_t dec_o
);
    import core_pkg::*;

    hs_state_e   state_q;
    word_t       pc_q;
    decode_pkt_t dec_q;
    decode_pkt_t dec_d;
    alu_op_e     op_3r;
    logic        capture;

    // A new instruction is taken only from idle
    assign capture     = (state_q == hs_idle) && instr_req_i;
    assign instr_ack_o = (state_q == hs_acked);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= hs_idle;
        end else begin
            case (state_q)
                hs_idle:  if (instr_req_i) state_q <= hs_acked;
                hs_acked: if (!instr_req_i) state_q <= hs_idle;  // Drop ack after req falls
                default:  state_q <= hs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (capture) begin
            pc_q <= pc_q + `CORE_PC_STEP;
        end
    end

    // 3R opcode lookup
    always_comb begin
        case (instr_data_i[31:15])
            `CORE_OP_ADD_W: op_3r = alu_add;
            `CORE_OP_SUB_W: op_3r = alu_sub;
            `CORE_OP_SLT:   op_3r = alu_slt;
            `CORE_OP_SLTU:  op_3r = alu_sltu;
            `CORE_OP_AND:   op_3r = alu_and;
            `CORE_OP_OR:    op_3r = alu_or;
            `CORE_OP_XOR:   op_3r = alu_xor;
            default:        op_3r = alu_none;
        endcase
    end

    always_comb begin
        dec_d        = '0;
        dec_d.pc     = pc_q;
        dec_d.rd     = instr_data_i[4:0];
        dec_d.rj     = instr_data_i[9:5];
        dec_d.rk     = instr_data_i[14:10];
        dec_d.alu_op = alu_none;
        if (instr_data_i[31:22] == `CORE_OP_ADDI_W) begin
            dec_d.alu_op  = alu_add;
            dec_d.imm     = {{20{instr_data_i[21]}}, instr_data_i[21:10]};  // si12
            dec_d.use_imm = 1'b1;
        end else if (instr_data_i[31:25] == `CORE_OP_LU12I_W) begin
            dec_d.alu_op  = alu_lui;
            dec_d.imm     = {instr_data_i[24:5], 12'h000};  // si20 << 12
            dec_d.use_imm = 1'b1;
        end else begin
            dec_d.alu_op = op_3r;
        end
        // Unknown ops and writes to r0 retire without a write
        dec_d.wen = (dec_d.alu_op != alu_none) && (dec_d.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_q <= dec_d;
        end
        if (rst_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q.valid <= capture;  // One cycle per capture
        end
    end

    assign dec_o = dec_q;

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0]             instr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_lui,
        alu_none
    } alu_op_e;

    // Four-phase port, ack is high exactly in hs_acked
    typedef enum logic {
        hs_idle,
        hs_acked
    } hs_state_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        word_t     imm;      // Already extended or shifted
        logic      use_imm;  // imm replaces the rk operand
        logic      wen;
    } decode_pkt_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      wen;
        word_t     result;
    } exec_pkt_t;

    // Same fields as the debug0_wb_* trace
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } commit_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

endpackage

`default_nettype wire

//--- hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath widths
`define CORE_XLEN       32
`define CORE_NUM_REGS   32
`define CORE_REG_AW     5

// Fetch side
`define CORE_RESET_PC   32'h1c000000
`define CORE_PC_STEP    32'd4

// 3R forms, matched on instr[31:15]
`define CORE_OP_ADD_W   17'h00020
`define CORE_OP_SUB_W   17'h00022
`define CORE_OP_SLT     17'h00024
`define CORE_OP_SLTU    17'h00025
`define CORE_OP_AND     17'h00029
`define CORE_OP_OR      17'h0002a
`define CORE_OP_XOR     17'h0002b

`define CORE_OP_ADDI_W  10'h00a  // instr[31:22]
`define CORE_OP_LU12I_W 7'h0a    // instr[31:25]

`endif
